// ==== sources.f ====
src/wb_pkg.sv
src/u2_map_pkg.sv
src/wb_intercon.sv
src/settings_bus.sv
src/board_ctrl_regs.sv
src/simple_timer.sv
src/pic.sv
src/status_readback.sv
src/u2_core.sv
verif/u2_core_tb.sv

// ==== verif/u2_core_tb.sv ====
// Control plane testbench
// Host bus tasks, a reference model of the board registers and the pic, and directed tests

`timescale 1ns/100ps
`default_nettype none

module u2_core_tb
   import wb_pkg::*, u2_map_pkg::*;
;

   // Cycle budget of each test
   localparam int TEST1_CYCLES = 10;
   localparam int TEST2_CYCLES = 160;
   localparam int TEST3_CYCLES = 40;
   localparam int TEST4_CYCLES = 20;
   localparam int TEST5_CYCLES = 80;
   localparam int TEST6_CYCLES = 300;
   // Run stops at twice the summed budget
   localparam int CYCLE_LIMIT  = 2 * (TEST1_CYCLES + TEST2_CYCLES + TEST3_CYCLES
                                      + TEST4_CYCLES + TEST5_CYCLES + TEST6_CYCLES);
   localparam int ACC_LIMIT    = 16;
   localparam int INT_LIMIT    = 8;

   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   // Result kinds of the reference model
   localparam int K_CLOCK     = 0;
   localparam int K_SERDES    = 1;
   localparam int K_ADC       = 2;
   localparam int K_PHY_N     = 3;
   localparam int K_LEDS      = 4;
   localparam int K_BOARD_ID  = 5;
   localparam int K_IRQ_LINES = 6;
   localparam int K_ENABLE    = 7;
   localparam int K_PENDING   = 8;
   localparam int K_VECTOR    = 9;

   logic         wb_clk;
   logic         wb_rst;
   wb_req_t      host_req;
   wb_rsp_t      host_rsp;
   logic         pps;
   logic         phy_int_n;
   logic         clk_status;
   logic         serdes_link_up;
   logic         run_rx;
   logic         run_tx;
   logic         sim_mode;
   logic [3:0]   clock_divider;
   clock_ctrl_t  clock_out;
   serdes_ctrl_t serdes_out;
   adc_ctrl_t    adc_out;
   logic         phy_reset_n;
   logic [7:0]   leds;
   logic         int_out;

   // Model state built up from the writes made so far
   logic [4:0]  m_clk;
   logic [3:0]  m_ser;
   logic [3:0]  m_adc;
   logic        m_phy;
   logic [7:0]  m_led_sw;
   logic [7:0]  m_led_src;
   irq_vec_t    m_enable;
   irq_vec_t    m_pending;

   logic [31:0] lfsr;
   logic        checking;
   int          cycle_cnt;

   u2_core u_dut (
      .wb_clk           (wb_clk),
      .wb_rst           (wb_rst),
      .host_req_i       (host_req),
      .host_rsp_o       (host_rsp),
      .pps_i            (pps),
      .phy_int_n_i      (phy_int_n),
      .clk_status_i     (clk_status),
      .serdes_link_up_i (serdes_link_up),
      .run_rx_i         (run_rx),
      .run_tx_i         (run_tx),
      .sim_mode_i       (sim_mode),
      .clock_divider_i  (clock_divider),
      .clock_o          (clock_out),
      .serdes_o         (serdes_out),
      .adc_o            (adc_out),
      .phy_reset_n_o    (phy_reset_n),
      .leds_o           (leds),
      .int_o            (int_out)
   );

   always #50 wb_clk = ~wb_clk;

   ////////////////////
   // Failure reporting and compare tasks
   task automatic stop_failed(input string line);
      $display("%s", line);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopping at first failure");
   endtask

   task automatic value_error(input string msg);
      stop_failed($sformatf("** Error at %0d ns: %s", $time, msg));
   endtask

   task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         value_error($sformatf("%s is 0x%08h, expected 0x%08h", what, got, exp));
      end
   endtask

   // Only the handshake flags are compared
   task automatic check_rsp(input wb_rsp_t got, input wb_rsp_t exp, input string what);
      if (got.ack !== exp.ack || got.err !== exp.err) begin
         value_error($sformatf("%s gave ack %b err %b, expected ack %b err %b",
                               what, got.ack, got.err, exp.ack, exp.err));
      end
   endtask

   task automatic check_clock(input clock_ctrl_t got, input clock_ctrl_t exp);
      if (got !== exp) begin
         value_error($sformatf("clock_o is 0x%02h, expected 0x%02h", got, exp));
      end
   endtask

   task automatic check_serdes(input serdes_ctrl_t got, input serdes_ctrl_t exp);
      if (got !== exp) begin
         value_error($sformatf("serdes_o is 0x%01h, expected 0x%01h", got, exp));
      end
   endtask

   task automatic check_adc(input adc_ctrl_t got, input adc_ctrl_t exp);
      if (got !== exp) begin
         value_error($sformatf("adc_o is 0x%01h, expected 0x%01h", got, exp));
      end
   endtask

   function automatic wb_rsp_t make_rsp(input logic ack, input logic err);
      wb_rsp_t r;
      r     = '0;
      r.ack = ack;
      r.err = err;
      return r;
   endfunction

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] next_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      end
      return v;
   endfunction

   ////////////////////
   // Reference model
   function automatic logic [31:0] ref_value(input int kind);
      logic [31:0] v;
      logic [7:0]  hw;
      irq_vec_t    act;
      v   = '0;
      // Hardware LED sources as wired at the top level
      hw  = {3'b000, run_tx, run_rx, clk_status, serdes_link_up, 1'b0};
      act = m_pending & m_enable;
      case (kind)
         K_CLOCK:   v[4:0] = m_clk;
         K_SERDES:  v[3:0] = m_ser;
         K_ADC:     v[3:0] = m_adc;
         K_PHY_N:   v[0]   = ~m_phy;
         K_LEDS: begin
            for (int i = 0; i < 8; i++) begin
               v[i] = m_led_src[i] ? hw[i] : m_led_sw[i];
            end
         end
         K_BOARD_ID: begin
            v[31]  = sim_mode;
            v[3:0] = clock_divider;
         end
         // Timers assumed idle when the lines are read
         K_IRQ_LINES: begin
            v[IRQ_PPS]        = pps;
            v[IRQ_PHY]        = ~phy_int_n;
            v[IRQ_CLK_STATUS] = clk_status;
         end
         K_ENABLE:  v[15:0] = m_enable;
         K_PENDING: v[15:0] = m_pending;
         K_VECTOR: begin
            v = 32'hFFFF_FFFF;
            for (int i = 0; i < 16; i++) begin
               if (act[i] && v == 32'hFFFF_FFFF) begin
                  v = i;
               end
            end
         end
         default: v = 'x;
      endcase
      return v;
   endfunction

   // Control outputs against the model on every edge
   always @(posedge wb_clk) begin : compare_outputs
      logic [31:0] e;
      if (checking) begin
         e = ref_value(K_CLOCK);
         check_clock(clock_out, e[4:0]);
         e = ref_value(K_SERDES);
         check_serdes(serdes_out, e[3:0]);
         e = ref_value(K_ADC);
         check_adc(adc_out, e[3:0]);
         check_word({31'd0, phy_reset_n}, ref_value(K_PHY_N), "phy_reset_n_o");
         check_word({24'd0, leds}, ref_value(K_LEDS), "leds_o");
      end
   end

   // Run length guard
   always @(posedge wb_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         stop_failed("Timeout: the tests did not finish within the cycle limit");
      end
   end

   ////////////////////
   // Bus tasks
   task automatic bus_access(input logic [5:0] slv, input logic [7:0] word,
                             input logic is_write, input logic [31:0] data,
                             output wb_rsp_t rsp);
      int waited;
      waited = 0;
      @(negedge wb_clk);
      host_req.adr.fld.slave    = slv;
      host_req.adr.fld.word     = word;
      host_req.adr.fld.byte_idx = 2'b00;
      host_req.dat              = data;
      host_req.sel              = 4'hF;
      host_req.we               = is_write;
      host_req.cyc              = 1'b1;
      host_req.stb              = 1'b1;
      do begin
         @(negedge wb_clk);
         waited++;
         if (waited > ACC_LIMIT) begin
            stop_failed("No ack or err came back for a bus access");
         end
      end while (!(host_rsp.ack || host_rsp.err));
      rsp          = host_rsp;
      host_req.cyc = 1'b0;
      host_req.stb = 1'b0;
      host_req.we  = 1'b0;
      // Idle cycle in which a setting lands
      @(negedge wb_clk);
   endtask

   task automatic write_ok(input logic [5:0] slv, input logic [7:0] word,
                           input logic [31:0] data, input string what);
      wb_rsp_t rsp;
      bus_access(slv, word, 1'b1, data, rsp);
      check_rsp(rsp, make_rsp(1'b1, 1'b0), what);
   endtask

   task automatic read_expect(input logic [5:0] slv, input logic [7:0] word,
                              input logic [31:0] exp, input string what);
      wb_rsp_t rsp;
      bus_access(slv, word, 1'b0, '0, rsp);
      check_rsp(rsp, make_rsp(1'b1, 1'b0), what);
      check_word(rsp.dat, exp, what);
   endtask

   // Write a setting and follow it in the model
   task automatic apply_setting(input logic [7:0] addr, input logic [31:0] data);
      write_ok(SLV_SETTINGS, addr, data, "settings write");
      case (addr)
         SR_CLK:     m_clk     = data[4:0];
         SR_SER:     m_ser     = data[3:0];
         SR_ADC:     m_adc     = data[3:0];
         SR_LED:     m_led_sw  = data[7:0];
         SR_PHY:     m_phy     = data[0];
         SR_LED_SRC: m_led_src = data[7:0];
         default: ;
      endcase
   endtask

   task automatic wait_int(input logic level);
      int waited;
      waited = 0;
      while (int_out !== level) begin
         @(negedge wb_clk);
         waited++;
         if (waited > INT_LIMIT) begin
            stop_failed($sformatf("int_o did not go to %0b in time", level));
         end
      end
   endtask

   ////////////////////
   // Tests
   initial begin : run_tests
      logic [7:0]  addrs [6];
      wb_rsp_t     rsp;
      logic [31:0] first_cnt;
      logic [4:0]  hw_bits;

      wb_clk         = 1'b0;
      wb_rst         = 1'b1;
      host_req       = '0;
      pps            = 1'b0;
      phy_int_n      = 1'b1;
      clk_status     = 1'b0;
      serdes_link_up = 1'b1;
      run_rx         = 1'b1;
      run_tx         = 1'b0;
      sim_mode       = 1'b1;
      clock_divider  = 4'hA;
      lfsr           = 32'hff60_d0bb;
      checking       = 1'b0;
      cycle_cnt      = 0;
      // Reset values
      m_clk          = '0;
      m_ser          = '0;
      m_adc          = '0;
      m_phy          = 1'b0;
      m_led_sw       = '0;
      m_led_src      = LED_SRC_RESET;
      m_enable       = '0;
      m_pending      = '0;
      addrs          = '{SR_CLK, SR_SER, SR_ADC, SR_LED, SR_PHY, SR_LED_SRC};

      repeat (4) @(negedge wb_clk);
      wb_rst   = 1'b0;
      checking = 1'b1;

      // Outputs idle after reset
      $display("Test 1: reset values");
      repeat (2) @(negedge wb_clk);
      check_rsp(host_rsp, make_rsp(1'b0, 1'b0), "idle response");
      check_word({31'd0, int_out}, 32'd0, "int_o after reset");

      $display("Test 2: setting registers and LED sources");
      for (int r = 0; r < 3; r++) begin
         for (int a = 0; a < 6; a++) begin
            apply_setting(addrs[a], next_bits(32));
         end
         for (int t = 0; t < 4; t++) begin
            @(negedge wb_clk);
            hw_bits        = next_bits(4);
            run_tx         = hw_bits[3];
            run_rx         = hw_bits[2];
            clk_status     = hw_bits[1];
            serdes_link_up = hw_bits[0];
            repeat (2) @(negedge wb_clk);
         end
      end
      // Unused address leaves every output alone
      apply_setting(8'd5, next_bits(32));

      $display("Test 3: status readback");
      @(negedge wb_clk);
      pps        = 1'b1;
      phy_int_n  = 1'b0;
      clk_status = 1'b1;
      read_expect(SLV_READBACK, RB_BOARD_ID, ref_value(K_BOARD_ID), "board id word");
      read_expect(SLV_READBACK, RB_IRQ, ref_value(K_IRQ_LINES), "irq lines word");
      read_expect(SLV_READBACK, 8'd0, 32'd0, "readback word 0");
      read_expect(SLV_READBACK, 8'd14, 32'd0, "readback word 14");
      write_ok(SLV_READBACK, RB_BOARD_ID, 32'h1234_5678, "readback write");
      read_expect(SLV_READBACK, RB_BOARD_ID, ref_value(K_BOARD_ID), "board id after write");
      pps        = 1'b0;
      phy_int_n  = 1'b1;
      clk_status = 1'b0;
      bus_access(SLV_READBACK, RB_CYCLES, 1'b0, '0, rsp);
      check_rsp(rsp, make_rsp(1'b1, 1'b0), "first cycle count read");
      first_cnt = rsp.dat;
      bus_access(SLV_READBACK, RB_CYCLES, 1'b0, '0, rsp);
      check_rsp(rsp, make_rsp(1'b1, 1'b0), "second cycle count read");
      if (!(rsp.dat > first_cnt)) begin
         value_error($sformatf("cycle count went from %0d to %0d", first_cnt, rsp.dat));
      end

      $display("Test 4: unmapped address");
      bus_access(6'b000000, 8'd0, 1'b0, '0, rsp);
      check_rsp(rsp, make_rsp(1'b0, 1'b1), "unmapped read");
      bus_access(6'b110100, 8'd3, 1'b1, next_bits(32), rsp);
      check_rsp(rsp, make_rsp(1'b0, 1'b1), "unmapped write");
      read_expect(SLV_READBACK, RB_BOARD_ID, ref_value(K_BOARD_ID), "read after err");

      $display("Test 5: interrupt controller");
      write_ok(SLV_PIC, 8'd1, 32'hFFFF, "clear pending");
      m_pending = '0;
      write_ok(SLV_PIC, 8'd0, 32'd1 << IRQ_PPS, "enable pps");
      m_enable  = 16'd1 << IRQ_PPS;
      wait_int(1'b0);
      @(negedge wb_clk);
      pps = 1'b1;
      m_pending[IRQ_PPS] = 1'b1;
      @(negedge wb_clk);
      pps = 1'b0;
      wait_int(1'b1);
      read_expect(SLV_PIC, 8'd0, ref_value(K_ENABLE), "enable mask");
      read_expect(SLV_PIC, 8'd1, ref_value(K_PENDING), "pending after pps");
      read_expect(SLV_PIC, 8'd2, ref_value(K_VECTOR), "vector after pps");
      write_ok(SLV_PIC, 8'd1, 32'd1 << IRQ_PPS, "clear pps");
      m_pending = '0;
      wait_int(1'b0);
      read_expect(SLV_PIC, 8'd1, ref_value(K_PENDING), "pending after clear");
      read_expect(SLV_PIC, 8'd2, ref_value(K_VECTOR), "vector when empty");
      // PHY line is active low
      write_ok(SLV_PIC, 8'd0, (32'd1 << IRQ_PPS) | (32'd1 << IRQ_PHY), "enable phy");
      m_enable[IRQ_PHY] = 1'b1;
      @(negedge wb_clk);
      phy_int_n = 1'b0;
      m_pending[IRQ_PHY] = 1'b1;
      wait_int(1'b1);
      read_expect(SLV_PIC, 8'd1, ref_value(K_PENDING), "pending after phy");
      read_expect(SLV_PIC, 8'd2, ref_value(K_VECTOR), "vector after phy");
      phy_int_n = 1'b1;
      write_ok(SLV_PIC, 8'd1, 32'd1 << IRQ_PHY, "clear phy");
      m_pending = '0;
      wait_int(1'b0);
      read_expect(SLV_PIC, 8'd1, ref_value(K_PENDING), "pending after phy clear");

      $display("Test 6: interval timer");
      write_ok(SLV_PIC, 8'd1, 32'hFFFF, "clear pending");
      m_pending = '0;
      write_ok(SLV_SETTINGS, SR_SIMTIMER, 32'd200, "one-shot start");
      read_expect(SLV_PIC, 8'd1, ref_value(K_PENDING), "pending before one-shot");
      repeat (210) @(negedge wb_clk);
      m_pending[IRQ_ONETIME] = 1'b1;
      read_expect(SLV_PIC, 8'd1, ref_value(K_PENDING), "pending after one-shot");
      write_ok(SLV_SETTINGS, SR_SIMTIMER + 8'd1, 32'd20, "periodic start");
      repeat (25) @(negedge wb_clk);
      m_pending[IRQ_PERIODIC] = 1'b1;
      read_expect(SLV_PIC, 8'd1, ref_value(K_PENDING), "pending after period");
      write_ok(SLV_PIC, 8'd1, 32'd1 << IRQ_PERIODIC, "clear periodic");
      m_pending[IRQ_PERIODIC] = 1'b0;
      read_expect(SLV_PIC, 8'd1, ref_value(K_PENDING), "pending after periodic clear");
      repeat (25) @(negedge wb_clk);
      m_pending[IRQ_PERIODIC] = 1'b1;
      read_expect(SLV_PIC, 8'd1, ref_value(K_PENDING), "pending after next period");
      write_ok(SLV_SETTINGS, SR_SIMTIMER + 8'd1, 32'd0, "periodic stop");

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/u2_core.sv ====
// Control plane top level
// Host Wishbone port, settings registers, timers, interrupt controller and readback

`timescale 1ns/100ps
`default_nettype none

module u2_core
   import wb_pkg::*, u2_map_pkg::*;
(
   input  wire          wb_clk,
   input  wire          wb_rst,
   input  wire wb_req_t host_req_i,
   output wb_rsp_t      host_rsp_o,
   input  wire          pps_i,
   input  wire          phy_int_n_i,
   input  wire          clk_status_i,
   input  wire          serdes_link_up_i,
   input  wire          run_rx_i,
   input  wire          run_tx_i,
   input  wire          sim_mode_i,
   input  wire [3:0]    clock_divider_i,
   output clock_ctrl_t  clock_o,
   output serdes_ctrl_t serdes_o,
   output adc_ctrl_t    adc_o,
   output logic         phy_reset_n_o,
   output logic [7:0]   leds_o,
   output logic         int_o
);

   wb_req_t    rb_req;
   wb_req_t    set_req;
   wb_req_t    pic_req;
   wb_rsp_t    rb_rsp;
   wb_rsp_t    set_rsp;
   wb_rsp_t    pic_rsp;
   set_bus_t   set_bus;
   logic       onetime_int;
   logic       periodic_int;
   irq_vec_t   irq;
   logic [7:0] led_hw;

   ////////////////////
   // Interconnect
   wb_intercon u_intercon (
      .wb_clk     (wb_clk),
      .wb_rst     (wb_rst),
      .host_req_i (host_req_i),
      .host_rsp_o (host_rsp_o),
      .rb_req_o   (rb_req),
      .set_req_o  (set_req),
      .pic_req_o  (pic_req),
      .rb_rsp_i   (rb_rsp),
      .set_rsp_i  (set_rsp),
      .pic_rsp_i  (pic_rsp)
   );

   ////////////////////
   // Settings bus and its consumers
   settings_bus u_settings_bus (
      .wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .req_i  (set_req),
      .rsp_o  (set_rsp),
      .set_o  (set_bus)
   );

   // Bit 0 has no hardware source
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};

   board_ctrl_regs u_board_ctrl_regs (
      .wb_clk        (wb_clk),
      .wb_rst        (wb_rst),
      .set_i         (set_bus),
      .led_hw_i      (led_hw),
      .clock_o       (clock_o),
      .serdes_o      (serdes_o),
      .adc_o         (adc_o),
      .phy_reset_n_o (phy_reset_n_o),
      .leds_o        (leds_o)
   );

   simple_timer u_simple_timer (
      .wb_clk     (wb_clk),
      .wb_rst     (wb_rst),
      .set_i      (set_bus),
      .onetime_o  (onetime_int),
      .periodic_o (periodic_int)
   );

   ////////////////////
   // Interrupt lines, PHY interrupt pin is active low
   always_comb begin
      irq                 = '0;
      irq[IRQ_ONETIME]    = onetime_int;
      irq[IRQ_PERIODIC]   = periodic_int;
      irq[IRQ_PPS]        = pps_i;
      irq[IRQ_PHY]        = ~phy_int_n_i;
      irq[IRQ_CLK_STATUS] = clk_status_i;
   end

   pic u_pic (
      .wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .req_i  (pic_req),
      .rsp_o  (pic_rsp),
      .irq_i  (irq),
      .int_o  (int_o)
   );

   status_readback u_status_readback (
      .wb_clk          (wb_clk),
      .wb_rst          (wb_rst),
      .req_i           (rb_req),
      .rsp_o           (rb_rsp),
      .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i),
      .irq_i           (irq)
   );

endmodule

`default_nettype wire

// ==== src/status_readback.sv ====
// Status readback window
// Read-only board id, live irq lines and a free-running cycle counter

`timescale 1ns/100ps
`default_nettype none

module status_readback
   import wb_pkg::*, u2_map_pkg::*;
(
   input  wire           wb_clk,
   input  wire           wb_rst,
   input  wire wb_req_t  req_i,
   output wb_rsp_t       rsp_o,
   input  wire           sim_mode_i,
   input  wire [3:0]     clock_divider_i,
   input  wire irq_vec_t irq_i
);

   logic [31:0] cycles_q;
   logic [31:0] dat_q;
   logic        ack_q;
   logic        acc_go;

   assign acc_go = req_i.cyc & req_i.stb & ~ack_q;

   // Counts every cycle since reset
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         cycles_q <= '0;
      end else begin
         cycles_q <= cycles_q + 32'd1;
      end
   end

   ////////////////////
   // Word select, writes get an ack and no effect
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= acc_go;
      end
      if (acc_go) begin
         case (req_i.adr.fld.word)
            RB_BOARD_ID: dat_q <= {sim_mode_i, 27'd0, clock_divider_i};
            RB_IRQ:      dat_q <= 32'(irq_i);
            RB_CYCLES:   dat_q <= cycles_q;
            default:     dat_q <= '0;
         endcase
      end
   end

   always_comb begin
      rsp_o.dat = dat_q;
      rsp_o.ack = ack_q;
      rsp_o.err = 1'b0;
   end

endmodule

`default_nettype wire

// ==== src/pic.sv ====
// Interrupt controller
// Captures rising irq edges into pending, masks them with enable, reports the vector

`timescale 1ns/100ps
`default_nettype none

module pic
   import wb_pkg::*, u2_map_pkg::*;
(
   input  wire           wb_clk,
   input  wire           wb_rst,
   input  wire wb_req_t  req_i,
   output wb_rsp_t       rsp_o,
   input  wire irq_vec_t irq_i,
   output logic          int_o
);

   irq_vec_t    enable_q;
   irq_vec_t    pending_q;
   irq_vec_t    irq_d;
   irq_vec_t    rise;
   irq_vec_t    active;
   logic        ack_q;
   logic [31:0] dat_q;
   logic        acc_go;
   logic        wr_go;
   logic [7:0]  word;

   // Index of lowest set bit, all ones when empty
   function automatic logic [31:0] lowest_set(input irq_vec_t v);
      logic [31:0] idx;
      idx = 32'hFFFF_FFFF;
      for (int i = $bits(irq_vec_t) - 1; i >= 0; i--) begin
         if (v[i]) begin
            idx = 32'(i);
         end
      end
      return idx;
   endfunction

   assign word   = req_i.adr.fld.word;
   assign acc_go = req_i.cyc & req_i.stb & ~ack_q;
   assign wr_go  = acc_go & req_i.we;
   assign rise   = irq_i & ~irq_d;
   assign active = pending_q & enable_q;

   // Previous irq sample for edge detect
   always_ff @(posedge wb_clk) begin
      irq_d <= irq_i;
   end

   ////////////////////
   // Enable, pending and output level
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         enable_q  <= '0;
         pending_q <= '0;
         int_o     <= 1'b0;
      end else begin
         if (wr_go && word == 8'd0) begin
            enable_q <= irq_vec_t'(req_i.dat[$bits(irq_vec_t)-1:0]);
         end
         // Ones written to word 1 clear, a new edge still lands
         if (wr_go && word == 8'd1) begin
            pending_q <= (pending_q & ~irq_vec_t'(req_i.dat[$bits(irq_vec_t)-1:0])) | rise;
         end else begin
            pending_q <= pending_q | rise;
         end
         int_o <= |active;
      end
   end

   ////////////////////
   // Bus side, one cycle read latency
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= acc_go;
      end
      if (acc_go) begin
         case (word)
            8'd0:    dat_q <= 32'(enable_q);
            8'd1:    dat_q <= 32'(pending_q);
            8'd2:    dat_q <= lowest_set(active);
            default: dat_q <= '0;
         endcase
      end
   end

   always_comb begin
      rsp_o.dat = dat_q;
      rsp_o.ack = ack_q;
      rsp_o.err = 1'b0;
   end

   // Interrupt only follows an overlap of pending and enable
   a_int_cause : assert property (@(posedge wb_clk) disable iff (wb_rst)
      int_o |-> $past(|(pending_q & enable_q)));

endmodule

`default_nettype wire

// ==== src/simple_timer.sv ====
// Interval timer
// One-shot and periodic interrupt pulses, both loaded over the settings bus

`timescale 1ns/100ps
`default_nettype none

module simple_timer
   import u2_map_pkg::*;
(
   input  wire           wb_clk,
   input  wire           wb_rst,
   input  wire set_bus_t set_i,
   output logic          onetime_o,
   output logic          periodic_o
);

   logic [31:0] onetime_cnt;
   logic [31:0] period_q;
   logic [31:0] periodic_cnt;
   logic        set_onetime;
   logic        set_periodic;

   assign set_onetime  = set_i.stb && (set_i.addr == SR_SIMTIMER);
   assign set_periodic = set_i.stb && (set_i.addr == SR_SIMTIMER + 8'd1);

   ////////////////////
   // One-shot countdown, zero means idle
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         onetime_cnt <= '0;
         onetime_o   <= 1'b0;
      end else begin
         if (set_onetime) begin
            onetime_cnt <= set_i.data;
         end else if (onetime_cnt != '0) begin
            onetime_cnt <= onetime_cnt - 32'd1;
         end
         // Fires once as the count runs out
         onetime_o <= (onetime_cnt == 32'd1) & ~set_onetime;
      end
   end

   ////////////////////
   // Periodic countdown, reloads from the period
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         period_q     <= '0;
         periodic_cnt <= '0;
         periodic_o   <= 1'b0;
      end else begin
         if (set_periodic) begin
            period_q     <= set_i.data;
            periodic_cnt <= set_i.data;
         end else if (periodic_cnt == 32'd1) begin
            periodic_cnt <= period_q;
         end else if (periodic_cnt != '0) begin
            periodic_cnt <= periodic_cnt - 32'd1;
         end
         periodic_o <= (periodic_cnt == 32'd1) & ~set_periodic;
      end
   end

endmodule

`default_nettype wire

// ==== src/board_ctrl_regs.sv ====
// Board setting registers
// Clock, SERDES, ADC, PHY reset and LED control, with per-bit LED source select

`timescale 1ns/100ps
`default_nettype none

module board_ctrl_regs
   import u2_map_pkg::*;
(
   input  wire           wb_clk,
   input  wire           wb_rst,
   input  wire set_bus_t set_i,
   input  wire [7:0]     led_hw_i,
   output clock_ctrl_t   clock_o,
   output serdes_ctrl_t  serdes_o,
   output adc_ctrl_t     adc_o,
   output logic          phy_reset_n_o,
   output logic [7:0]    leds_o
);

   logic       phy_rst_q;
   logic [7:0] led_sw_q;
   // 1 = hardware drives the LED, 0 = software
   logic [7:0] led_src_q;

   // Each register loads the low data bits on its own address
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         clock_o   <= '0;
         serdes_o  <= '0;
         adc_o     <= '0;
         phy_rst_q <= 1'b0;
         led_sw_q  <= '0;
         led_src_q <= LED_SRC_RESET;
      end else if (set_i.stb) begin
         case (set_i.addr)
            SR_CLK:     clock_o   <= clock_ctrl_t'(set_i.data[$bits(clock_ctrl_t)-1:0]);
            SR_SER:     serdes_o  <= serdes_ctrl_t'(set_i.data[$bits(serdes_ctrl_t)-1:0]);
            SR_ADC:     adc_o     <= adc_ctrl_t'(set_i.data[$bits(adc_ctrl_t)-1:0]);
            SR_LED:     led_sw_q  <= set_i.data[7:0];
            SR_PHY:     phy_rst_q <= set_i.data[0];
            SR_LED_SRC: led_src_q <= set_i.data[7:0];
            default: ;
         endcase
      end
   end

   // PHY reset pin is active low
   assign phy_reset_n_o = ~phy_rst_q;

   // Per-bit LED source mix
   assign leds_o = (led_src_q & led_hw_i) | (~led_src_q & led_sw_q);

endmodule

`default_nettype wire

// ==== src/settings_bus.sv ====
// Settings bus slave
// Turns each bus write into a one-cycle setting strobe

`timescale 1ns/100ps
`default_nettype none

module settings_bus
   import wb_pkg::*, u2_map_pkg::*;
(
   input  wire          wb_clk,
   input  wire          wb_rst,
   input  wire wb_req_t req_i,
   output wb_rsp_t      rsp_o,
   output set_bus_t     set_o
);

   logic ack_q;
   logic acc_go;

   // First cycle of an access
   assign acc_go = req_i.cyc & req_i.stb & ~ack_q;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         ack_q     <= 1'b0;
         set_o.stb <= 1'b0;
      end else begin
         ack_q     <= acc_go;
         // Strobe rides with the ack of a write
         set_o.stb <= acc_go & req_i.we;
      end
      if (acc_go) begin
         set_o.addr <= req_i.adr.fld.word;
         set_o.data <= req_i.dat;
      end
   end

   // Write-only slave, reads return zero
   always_comb begin
      rsp_o.dat = '0;
      rsp_o.ack = ack_q;
      rsp_o.err = 1'b0;
   end

   a_stb_with_ack : assert property (@(posedge wb_clk) disable iff (wb_rst)
      set_o.stb |-> rsp_o.ack);

endmodule

`default_nettype wire

// ==== src/wb_intercon.sv ====
// Single-master Wishbone interconnect
// Decodes the slave region, fans the request out and muxes the response back

`timescale 1ns/100ps
`default_nettype none

module wb_intercon
   import wb_pkg::*, u2_map_pkg::*;
(
   input  wire          wb_clk,
   input  wire          wb_rst,
   input  wire wb_req_t host_req_i,
   output wb_rsp_t      host_rsp_o,
   output wb_req_t      rb_req_o,
   output wb_req_t      set_req_o,
   output wb_req_t      pic_req_o,
   input  wire wb_rsp_t rb_rsp_i,
   input  wire wb_rsp_t set_rsp_i,
   input  wire wb_rsp_t pic_rsp_i
);

   logic [5:0] slv;
   logic       sel_rb;
   logic       sel_set;
   logic       sel_pic;
   logic       sel_none;
   logic       err_q;

   // Region decode
   assign slv      = host_req_i.adr.fld.slave;
   assign sel_rb   = (slv == SLV_READBACK);
   assign sel_set  = (slv == SLV_SETTINGS);
   assign sel_pic  = (slv == SLV_PIC);
   assign sel_none = ~(sel_rb | sel_set | sel_pic);

   // Request copies, strobes only reach the selected slave
   always_comb begin
      rb_req_o      = host_req_i;
      rb_req_o.cyc  = host_req_i.cyc & sel_rb;
      rb_req_o.stb  = host_req_i.stb & sel_rb;
      set_req_o     = host_req_i;
      set_req_o.cyc = host_req_i.cyc & sel_set;
      set_req_o.stb = host_req_i.stb & sel_set;
      pic_req_o     = host_req_i;
      pic_req_o.cyc = host_req_i.cyc & sel_pic;
      pic_req_o.stb = host_req_i.stb & sel_pic;
   end

   // Unclaimed space answers with err, same timing as a slave ack
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         err_q <= 1'b0;
      end else begin
         err_q <= host_req_i.cyc & host_req_i.stb & sel_none & ~err_q;
      end
   end

   // Response mux
   always_comb begin
      host_rsp_o = '0;
      if (sel_rb) begin
         host_rsp_o = rb_rsp_i;
      end else if (sel_set) begin
         host_rsp_o = set_rsp_i;
      end else if (sel_pic) begin
         host_rsp_o = pic_rsp_i;
      end
      host_rsp_o.err = host_rsp_o.err | err_q;
   end

   ////////////////////
   // Bus checks
   a_ack_err_excl : assert property (@(posedge wb_clk) disable iff (wb_rst)
      !(host_rsp_o.ack && host_rsp_o.err));

   a_one_slave : assert property (@(posedge wb_clk) disable iff (wb_rst)
      $onehot0({rb_req_o.stb, set_req_o.stb, pic_req_o.stb}));

endmodule

`default_nettype wire

// ==== src/u2_map_pkg.sv ====
// Board map package
// Slave regions, setting addresses, interrupt lines and control output bundles

`default_nettype none

package u2_map_pkg;

   ////////////////////
   // Slave field values of the address map
   localparam logic [5:0] SLV_READBACK = 6'b110011;
   localparam logic [5:0] SLV_SETTINGS = 6'b110101;
   localparam logic [5:0] SLV_PIC      = 6'b110110;

   ////////////////////
   // Setting addresses
   localparam logic [7:0] SR_CLK      = 8'd0;
   localparam logic [7:0] SR_SER      = 8'd1;
   localparam logic [7:0] SR_ADC      = 8'd2;
   localparam logic [7:0] SR_LED      = 8'd3;
   localparam logic [7:0] SR_PHY      = 8'd4;
   localparam logic [7:0] SR_LED_SRC  = 8'd8;
   // Two words, one-shot then periodic
   localparam logic [7:0] SR_SIMTIMER = 8'd198;

   // Bits 4..1 driven by hardware after reset
   localparam logic [7:0] LED_SRC_RESET = 8'h1E;

   ////////////////////
   // Interrupt bit positions
   localparam int IRQ_ONETIME    = 0;
   localparam int IRQ_PERIODIC   = 1;
   localparam int IRQ_PPS        = 2;
   localparam int IRQ_PHY        = 3;
   localparam int IRQ_CLK_STATUS = 4;

   typedef logic [15:0] irq_vec_t;

   // Setting strobe with its word address and data
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // Clock generator control
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   // Readback word indices
   localparam logic [7:0] RB_BOARD_ID = 8'd9;
   localparam logic [7:0] RB_IRQ      = 8'd13;
   localparam logic [7:0] RB_CYCLES   = 8'd15;

endpackage

`default_nettype wire

// ==== src/wb_pkg.sv ====
// Wishbone bus package
// Bus widths, request and response bundles, and the two views of a bus address

`default_nettype none

package wb_pkg;

   // Bus widths
   localparam int WB_DW = 32;
   localparam int WB_AW = 16;
   localparam int WB_SW = 4;

   // One byte address seen as raw bits or as region, word and byte fields
   typedef union packed {
      logic [WB_AW-1:0] raw;
      struct packed {
         // 1 KB region, decoded by the interconnect
         logic [5:0] slave;
         // Register index inside a slave
         logic [7:0] word;
         logic [1:0] byte_idx;
      } fld;
   } wb_addr_u;

   // Master to slave, 55 bits
   typedef struct packed {
      wb_addr_u         adr;
      logic [WB_DW-1:0] dat;
      logic [WB_SW-1:0] sel;
      logic             we;
      logic             cyc;
      logic             stb;
   } wb_req_t;

   // Slave to master, 34 bits
   typedef struct packed {
      logic [WB_DW-1:0] dat;
      logic             ack;
      logic             err;
   } wb_rsp_t;

endpackage

`default_nettype wire
